// ==== include/cache_params.svh ====
// Cache system sizes
// Address and data widths, line counts and main memory timing
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// Word address and data word widths
`define CACHE_ADDR_W  12
`define CACHE_DATA_W  32

// Line counts with one word per line
`define ICACHE_LINES  16
`define DCACHE_LINES  16

// Cycles of one unbroken grant before memory answers
`define MEM_LATENCY   4

// Memory depth covers the whole word address space
`define MEM_WORDS     4096

`endif

// ==== hdl/cache_pkg.sv ====
// Cache system types
// Vector types for addresses, data, index and tag, plus the miss FSM states
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0] addr_t;  // Word address
    typedef logic [`CACHE_DATA_W-1:0] data_t;  // Data word

    // Both caches have the same line count, so one index width serves both
    localparam int INDEX_W = $clog2(`DCACHE_LINES);

    typedef logic [INDEX_W-1:0]               index_t;  // Low address bits
    typedef logic [`CACHE_ADDR_W-INDEX_W-1:0] tag_t;    // High address bits

    // Miss FSM shared by both caches
    typedef enum logic [1:0] {
        MISS_IDLE,        // Ready for a request
        MISS_WAIT_GRANT,  // Busy raised while memory is not yet ours
        MISS_WAIT_DONE,   // Granted and waiting for the done pulse
        MISS_RESPOND      // Valid pulse out while still taking requests
    } miss_state_t;

endpackage

// ==== hdl/cache_arbiter.sv ====
// Memory arbiter for the cache pair
// Registered fixed-priority grants, I-cache first, no lock
`timescale 1ns/1ps

module cache_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic icache_busy,  // I-cache miss in progress
    input  logic dcache_busy,  // D-cache miss or write-through in progress
    output logic mem_en,       // Memory has an owner
    output logic i_grant,
    output logic d_grant
);

    logic i_grant_nxt;
    logic d_grant_nxt;

    ////////////////////
    // Priority choice
    ////////////////////
    assign i_grant_nxt = icache_busy;                 // I side always wins
    assign d_grant_nxt = dcache_busy & ~icache_busy;  // D only when I is quiet

    // Grants follow busy by one cycle; a D owner loses memory as soon as I asks
    always_ff @(posedge clk) begin
        if (rst) begin
            i_grant <= 1'b0;
            d_grant <= 1'b0;
            mem_en  <= 1'b0;
        end else begin
            i_grant <= i_grant_nxt;
            d_grant <= d_grant_nxt;
            mem_en  <= i_grant_nxt | d_grant_nxt;  // Same as OR of the new grants
        end
    end

endmodule

// ==== hdl/icache.sv ====
// Instruction cache
// Direct-mapped, read-only, one word per line; misses go through the arbiter
`timescale 1ns/1ps
`include "cache_params.svh"

module icache (
    input  logic               clk,
    input  logic               rst,
    input  logic               i_req,       // One-cycle fetch strobe
    input  cache_pkg::addr_t   i_addr,
    input  logic               i_grant,
    input  logic               i_done,      // Memory word ready this cycle
    input  cache_pkg::data_t   mem_rdata,
    output cache_pkg::data_t   i_data,
    output logic               i_valid,     // One-cycle answer strobe
    output logic               icache_busy,
    output cache_pkg::addr_t   i_mem_addr
);

    localparam int TAG_W = $bits(cache_pkg::tag_t);

    // Line storage
    cache_pkg::tag_t          tag_q  [`ICACHE_LINES];
    cache_pkg::data_t         data_q [`ICACHE_LINES];
    logic [`ICACHE_LINES-1:0] line_valid;

    cache_pkg::miss_state_t state;
    cache_pkg::addr_t       miss_addr;  // Address of the outstanding miss

    cache_pkg::index_t req_idx;
    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t miss_idx;
    logic              req_hit;
    logic              accepting;      // New request allowed when idle or answering
    logic              hit_take;
    logic              miss_take;
    logic              fill;           // Done pulse for our miss

    ////////////////////
    // Lookup
    ////////////////////
    assign req_idx  = cache_pkg::index_t'(i_addr);
    assign req_tag  = i_addr[`CACHE_ADDR_W-1 -: TAG_W];
    assign miss_idx = cache_pkg::index_t'(miss_addr);
    assign req_hit  = line_valid[req_idx] && (tag_q[req_idx] == req_tag);

    assign accepting = (state == cache_pkg::MISS_IDLE) ||
                       (state == cache_pkg::MISS_RESPOND);
    assign hit_take  = accepting && i_req && req_hit;
    assign miss_take = accepting && i_req && !req_hit;
    // Done can beat the grant state change when the latency is one cycle
    assign fill      = i_done && ((state == cache_pkg::MISS_WAIT_GRANT) ||
                                  (state == cache_pkg::MISS_WAIT_DONE));

    assign icache_busy = (state == cache_pkg::MISS_WAIT_GRANT) ||
                         (state == cache_pkg::MISS_WAIT_DONE);
    assign i_mem_addr  = miss_addr;

    ////////////////////
    // Miss FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= cache_pkg::MISS_IDLE;
            line_valid <= '0;
            i_valid    <= 1'b0;
        end else begin
            i_valid <= hit_take | fill;  // Answer one cycle after hit or fill
            case (state)
                cache_pkg::MISS_IDLE,
                cache_pkg::MISS_RESPOND: begin
                    state <= miss_take ? cache_pkg::MISS_WAIT_GRANT
                                       : cache_pkg::MISS_IDLE;
                end
                cache_pkg::MISS_WAIT_GRANT: begin
                    if (fill)
                        state <= cache_pkg::MISS_RESPOND;
                    else if (i_grant)
                        state <= cache_pkg::MISS_WAIT_DONE;
                end
                cache_pkg::MISS_WAIT_DONE: begin
                    if (fill)
                        state <= cache_pkg::MISS_RESPOND;
                end
                default: state <= cache_pkg::MISS_IDLE;
            endcase
            if (fill)
                line_valid[miss_idx] <= 1'b1;
        end
    end

    // Line fill and answer data
    always_ff @(posedge clk) begin
        if (miss_take)
            miss_addr <= i_addr;
        if (hit_take)
            i_data <= data_q[req_idx];
        if (fill) begin
            tag_q[miss_idx]  <= miss_addr[`CACHE_ADDR_W-1 -: TAG_W];
            data_q[miss_idx] <= mem_rdata;
            i_data           <= mem_rdata;  // Forward the fetched word
        end
    end

endmodule

// ==== hdl/dcache.sv ====
// Data cache
// Direct-mapped, one word per line, write-through with write-allocate
// Every write waits for memory to confirm before answering
`timescale 1ns/1ps
`include "cache_params.svh"

module dcache (
    input  logic               clk,
    input  logic               rst,
    input  logic               d_req,        // One-cycle access strobe
    input  logic               d_we,         // Write when high
    input  cache_pkg::addr_t   d_addr,
    input  cache_pkg::data_t   d_wdata,
    input  logic               d_grant,
    input  logic               d_done,
    input  cache_pkg::data_t   mem_rdata,
    output cache_pkg::data_t   d_rdata,
    output logic               d_valid,      // One-cycle answer strobe
    output logic               dcache_busy,
    output cache_pkg::addr_t   d_mem_addr,
    output logic               d_mem_we,
    output cache_pkg::data_t   d_mem_wdata
);

    localparam int TAG_W = $bits(cache_pkg::tag_t);

    // Line storage
    cache_pkg::tag_t          tag_q  [`DCACHE_LINES];
    cache_pkg::data_t         data_q [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] line_valid;

    cache_pkg::miss_state_t state;
    cache_pkg::addr_t       xfer_addr;   // Held for the whole transfer
    cache_pkg::data_t       xfer_wdata;  // Resent as is after a preemption
    logic                   xfer_we;

    cache_pkg::index_t req_idx;
    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t xfer_idx;
    logic              req_hit;
    logic              accepting;
    logic              hit_take;     // Read hit answered next cycle
    logic              xfer_take;    // Read miss or any write
    logic              wr_take;
    logic              finish;       // Our done pulse

    ////////////////////
    // Lookup
    ////////////////////
    assign req_idx  = cache_pkg::index_t'(d_addr);
    assign req_tag  = d_addr[`CACHE_ADDR_W-1 -: TAG_W];
    assign xfer_idx = cache_pkg::index_t'(xfer_addr);
    assign req_hit  = line_valid[req_idx] && (tag_q[req_idx] == req_tag);

    assign accepting = (state == cache_pkg::MISS_IDLE) ||
                       (state == cache_pkg::MISS_RESPOND);
    assign hit_take  = accepting && d_req && !d_we && req_hit;
    assign xfer_take = accepting && d_req && (d_we || !req_hit);
    assign wr_take   = accepting && d_req && d_we;
    assign finish    = d_done && ((state == cache_pkg::MISS_WAIT_GRANT) ||
                                  (state == cache_pkg::MISS_WAIT_DONE));

    assign dcache_busy = (state == cache_pkg::MISS_WAIT_GRANT) ||
                         (state == cache_pkg::MISS_WAIT_DONE);
    // Memory side stays stable from acceptance to done
    assign d_mem_addr  = xfer_addr;
    assign d_mem_we    = xfer_we;
    assign d_mem_wdata = xfer_wdata;

    ////////////////////
    // Miss FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= cache_pkg::MISS_IDLE;
            line_valid <= '0;
            d_valid    <= 1'b0;
            xfer_we    <= 1'b0;
        end else begin
            d_valid <= hit_take | finish;
            case (state)
                cache_pkg::MISS_IDLE,
                cache_pkg::MISS_RESPOND: begin
                    state <= xfer_take ? cache_pkg::MISS_WAIT_GRANT
                                       : cache_pkg::MISS_IDLE;
                    if (xfer_take)
                        xfer_we <= d_we;
                end
                cache_pkg::MISS_WAIT_GRANT: begin
                    if (finish)
                        state <= cache_pkg::MISS_RESPOND;
                    else if (d_grant)
                        state <= cache_pkg::MISS_WAIT_DONE;
                end
                cache_pkg::MISS_WAIT_DONE: begin
                    if (finish)
                        state <= cache_pkg::MISS_RESPOND;
                end
                default: state <= cache_pkg::MISS_IDLE;
            endcase
            if (wr_take)
                line_valid[req_idx] <= 1'b1;   // Write allocates right away
            else if (finish && !xfer_we)
                line_valid[xfer_idx] <= 1'b1;  // Read fill
        end
    end

    // Line data, transfer payload and answer data
    always_ff @(posedge clk) begin
        if (xfer_take) begin
            xfer_addr  <= d_addr;
            xfer_wdata <= d_wdata;
        end
        if (wr_take) begin
            tag_q[req_idx]  <= req_tag;   // Update or replace the line
            data_q[req_idx] <= d_wdata;
        end
        if (hit_take)
            d_rdata <= data_q[req_idx];
        if (finish) begin
            if (xfer_we) begin
                d_rdata <= xfer_wdata;  // Echo the word now in memory
            end else begin
                tag_q[xfer_idx]  <= xfer_addr[`CACHE_ADDR_W-1 -: TAG_W];
                data_q[xfer_idx] <= mem_rdata;
                d_rdata          <= mem_rdata;
            end
        end
    end

endmodule

// ==== hdl/main_memory.sv ====
// Shared main memory model
// Word array with a fixed access latency; serves the granted cache
// and pulses that cache's done when the access completes
`timescale 1ns/1ps
`include "cache_params.svh"

module main_memory (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_en,       // Some cache owns memory
    input  logic               i_grant,
    input  logic               d_grant,
    input  cache_pkg::addr_t   i_mem_addr,
    input  cache_pkg::addr_t   d_mem_addr,
    input  logic               d_mem_we,
    input  cache_pkg::data_t   d_mem_wdata,
    output cache_pkg::data_t   mem_rdata,    // Valid with the done pulse
    output logic               i_done,
    output logic               d_done
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    cache_pkg::data_t mem [`MEM_WORDS];

    logic [CNT_W-1:0] cnt;        // Earlier cycles of the current grant
    logic [CNT_W-1:0] cnt_cur;
    logic             finished;   // Access already answered for this grant
    logic             fin_cur;
    logic             i_grant_q;
    logic             d_grant_q;
    logic             same_owner;
    logic             done;
    cache_pkg::addr_t rd_addr;

    // Contents start at zero; reset leaves them alone
    initial begin
        for (int w = 0; w < `MEM_WORDS; w++) begin
            mem[w] = '0;
        end
    end

    ////////////////////
    // Latency count
    ////////////////////
    // A change of owner restarts the count, so a preempted access starts over
    assign same_owner = (i_grant == i_grant_q) && (d_grant == d_grant_q);
    assign cnt_cur    = same_owner ? cnt : '0;
    assign fin_cur    = same_owner && finished;
    assign done       = mem_en && !fin_cur && (cnt_cur == CNT_W'(`MEM_LATENCY - 1));

    assign i_done = done & i_grant;
    assign d_done = done & d_grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt       <= '0;
            finished  <= 1'b0;
            i_grant_q <= 1'b0;
            d_grant_q <= 1'b0;
        end else begin
            i_grant_q <= i_grant;
            d_grant_q <= d_grant;
            if (!mem_en) begin
                cnt      <= '0;
                finished <= 1'b0;
            end else begin
                finished <= fin_cur | done;  // Hold until the grant drops
                if (!fin_cur)
                    cnt <= cnt_cur + 1'b1;
            end
        end
    end

    ////////////////////
    // Array access
    ////////////////////
    assign rd_addr   = d_grant ? d_mem_addr : i_mem_addr;
    assign mem_rdata = mem[rd_addr];

    // Write lands only on completion
    always_ff @(posedge clk) begin
        if (d_done && d_mem_we)
            mem[d_mem_addr] <= d_mem_wdata;
    end

endmodule

// ==== hdl/cache_top.sv ====
// Cache system top level
// I-cache and D-cache sharing one main memory through the miss arbiter
`timescale 1ns/1ps

module cache_top (
    input  logic             clk,
    input  logic             rst,
    // Instruction side
    input  logic             i_req,
    input  cache_pkg::addr_t i_addr,
    output cache_pkg::data_t i_data,
    output logic             i_valid,
    // Data side
    input  logic             d_req,
    input  logic             d_we,
    input  cache_pkg::addr_t d_addr,
    input  cache_pkg::data_t d_wdata,
    output cache_pkg::data_t d_rdata,
    output logic             d_valid
);

    logic             icache_busy;
    logic             dcache_busy;
    logic             i_grant;
    logic             d_grant;
    logic             mem_en;
    logic             i_done;
    logic             d_done;
    cache_pkg::data_t mem_rdata;     // Shared by both caches
    cache_pkg::addr_t i_mem_addr;
    cache_pkg::addr_t d_mem_addr;
    logic             d_mem_we;
    cache_pkg::data_t d_mem_wdata;

    icache u_icache (
        .clk         (clk),
        .rst         (rst),
        .i_req       (i_req),
        .i_addr      (i_addr),
        .i_grant     (i_grant),
        .i_done      (i_done),
        .mem_rdata   (mem_rdata),
        .i_data      (i_data),
        .i_valid     (i_valid),
        .icache_busy (icache_busy),
        .i_mem_addr  (i_mem_addr)
    );

    dcache u_dcache (
        .clk         (clk),
        .rst         (rst),
        .d_req       (d_req),
        .d_we        (d_we),
        .d_addr      (d_addr),
        .d_wdata     (d_wdata),
        .d_grant     (d_grant),
        .d_done      (d_done),
        .mem_rdata   (mem_rdata),
        .d_rdata     (d_rdata),
        .d_valid     (d_valid),
        .dcache_busy (dcache_busy),
        .d_mem_addr  (d_mem_addr),
        .d_mem_we    (d_mem_we),
        .d_mem_wdata (d_mem_wdata)
    );

    cache_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .icache_busy (icache_busy),
        .dcache_busy (dcache_busy),
        .mem_en      (mem_en),
        .i_grant     (i_grant),
        .d_grant     (d_grant)
    );

    main_memory u_memory (
        .clk         (clk),
        .rst         (rst),
        .mem_en      (mem_en),
        .i_grant     (i_grant),
        .d_grant     (d_grant),
        .i_mem_addr  (i_mem_addr),
        .d_mem_addr  (d_mem_addr),
        .d_mem_we    (d_mem_we),
        .d_mem_wdata (d_mem_wdata),
        .mem_rdata   (mem_rdata),
        .i_done      (i_done),
        .d_done      (d_done)
    );

endmodule

// ==== tb/tb_cache_top.sv ====
// Testbench for the cache system
// Replays the stimulus file against a reference memory and tag model,
// checking data and valid latency of every access
`timescale 1ns/1ps
`include "cache_params.svh"

module tb_cache_top;

    localparam int TIMEOUT  = 200;                      // Cycles per wait
    localparam int INDEX_W  = $bits(cache_pkg::index_t);
    localparam int MISS_LAT = `MEM_LATENCY + 2;         // Uncontested request to valid

    logic             clk;
    logic             rst;
    logic             i_req;
    cache_pkg::addr_t i_addr;
    cache_pkg::data_t i_data;
    logic             i_valid;
    logic             d_req;
    logic             d_we;
    cache_pkg::addr_t d_addr;
    cache_pkg::data_t d_wdata;
    cache_pkg::data_t d_rdata;
    logic             d_valid;

    // Reference memory and tag model
    cache_pkg::data_t         ref_mem   [`MEM_WORDS];
    cache_pkg::tag_t          i_tag_ref [`ICACHE_LINES];
    cache_pkg::tag_t          d_tag_ref [`DCACHE_LINES];
    logic [`ICACHE_LINES-1:0] i_vld_ref;
    logic [`DCACHE_LINES-1:0] d_vld_ref;

    // Current group of accesses from one line or a pair
    int               tnum     [2];
    logic [7:0]       side     [2];  // "I" or "D"
    logic [15:0]      op       [2];  // Pair prefix in the upper byte
    cache_pkg::addr_t addr     [2];
    cache_pkg::data_t wdata    [2];
    cache_pkg::data_t fexp     [2];  // Expected column of the file
    cache_pkg::data_t exp_data [2];
    int               exp_lat  [2];  // Zero when contested
    int               off      [2];  // Issue cycle within the group
    int               n_acc;
    int               ki;
    int               kd;

    int               i_lat;
    int               d_lat;
    cache_pkg::data_t i_got;
    cache_pkg::data_t d_got;

    int fd;
    int cur_test;
    int test_errs;
    int tests_passed;
    int tests_failed;
    bit aborted;
    bit ok;

    cache_top u_cache_top (
        .clk     (clk),
        .rst     (rst),
        .i_req   (i_req),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .i_valid (i_valid),
        .d_req   (d_req),
        .d_we    (d_we),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_valid (d_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    // Reads the next data line into slot k and skips comments and blank lines
    task automatic read_line(input int k, output bit got);
        string line;
        int    n;
        got = 1'b0;
        while (!got && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#")
                got = ($sscanf(line, "%d %s %s %h %h %h", tnum[k], side[k], op[k],
                               addr[k], wdata[k], fexp[k]) == 6);
        end
    endtask

    // Tag model lookup; the line holds the address afterwards either way
    function automatic bit model_access(input logic [7:0] s, input cache_pkg::addr_t a);
        cache_pkg::index_t idx;
        cache_pkg::tag_t   tg;
        bit                hit;
        idx = a[INDEX_W-1:0];
        tg  = a[`CACHE_ADDR_W-1:INDEX_W];
        if (s == "I") begin
            hit            = i_vld_ref[idx] && (i_tag_ref[idx] == tg);
            i_vld_ref[idx] = 1'b1;
            i_tag_ref[idx] = tg;
        end else begin
            hit            = d_vld_ref[idx] && (d_tag_ref[idx] == tg);
            d_vld_ref[idx] = 1'b1;  // Writes allocate too
            d_tag_ref[idx] = tg;
        end
        return hit;
    endfunction

    ////////////////////
    // Expectations
    ////////////////////
    task automatic predict();
        bit hit;
        bit we;
        ki = -1;
        kd = -1;
        for (int k = 0; k < n_acc; k++) begin
            we          = (op[k][7:0] == "W");
            hit         = model_access(side[k], addr[k]);
            exp_data[k] = we ? wdata[k] : ref_mem[addr[k]];  // Write echoes its data
            // I always wins memory, so only a paired D access has no fixed latency
            if (n_acc == 2 && side[k] == "D")
                exp_lat[k] = 0;
            else
                exp_lat[k] = (hit && !we) ? 1 : MISS_LAT;
            if (exp_data[k] !== fexp[k]) begin
                $display("test %0d: file expects %h at %h but the reference model holds %h",
                         cur_test, fexp[k], addr[k], exp_data[k]);
                test_errs++;
            end
            if (side[k] == "I")
                ki = k;
            else
                kd = k;
        end
        for (int k = 0; k < n_acc; k++) begin
            if (op[k][7:0] == "W")
                ref_mem[addr[k]] = wdata[k];
        end
    endtask

    ////////////////////
    // Issue and wait
    ////////////////////
    task automatic run_access();
        bit i_pend;
        bit d_pend;
        int i_off;
        int d_off;
        int cyc;
        i_pend = (ki >= 0);
        d_pend = (kd >= 0);
        i_off  = i_pend ? off[ki] : -1;
        d_off  = d_pend ? off[kd] : -1;
        i_lat  = -1;
        d_lat  = -1;
        cyc    = 0;
        while ((i_pend || d_pend) && cyc < TIMEOUT) begin
            @(posedge clk);
            i_req <= (cyc == i_off);   // One-cycle strobes
            d_req <= (cyc == d_off);
            if (cyc == i_off)
                i_addr <= addr[ki];
            if (cyc == d_off) begin
                d_we    <= (op[kd][7:0] == "W");
                d_addr  <= addr[kd];
                d_wdata <= wdata[kd];
            end
            @(negedge clk);            // Outputs settled mid-cycle
            if (i_pend && cyc > i_off && i_valid) begin
                i_pend = 1'b0;
                i_lat  = cyc - i_off;
                i_got  = i_data;
            end
            if (d_pend && cyc > d_off && d_valid) begin
                d_pend = 1'b0;
                d_lat  = cyc - d_off;
                d_got  = d_rdata;
            end
            cyc++;
        end
        if (i_pend || d_pend) begin
            $display("test %0d: no %s pulse within %0d cycles of the request",
                     cur_test, i_pend ? "i_valid" : "d_valid", TIMEOUT);
            test_errs++;
            aborted = 1'b1;
        end
    endtask

    task automatic check_group();
        cache_pkg::data_t got;
        int               lat;
        string            dname;
        string            vname;
        for (int k = 0; k < n_acc; k++) begin
            if (side[k] == "I") begin
                got   = i_got;
                lat   = i_lat;
                dname = "i_data";
                vname = "i_valid";
            end else begin
                got   = d_got;
                lat   = d_lat;
                dname = "d_rdata";
                vname = "d_valid";
            end
            if (got !== exp_data[k]) begin
                $display("mismatch %s test %0d addr %h: expected %h, got %h",
                         dname, cur_test, addr[k], exp_data[k], got);
                test_errs++;
            end
            if (exp_lat[k] != 0 && lat != exp_lat[k]) begin
                $display("mismatch %s latency test %0d addr %h: expected %h, got %h",
                         vname, cur_test, addr[k], exp_lat[k], lat);
                test_errs++;
            end
        end
        if (n_acc == 2 && off[1] == 0 && i_lat > d_lat) begin
            $display("test %0d: i_valid came after d_valid for requests in the same cycle",
                     cur_test);
            test_errs++;
        end
    endtask

    task automatic finish_test(input int t);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0d passed", t);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", t, test_errs);
        end
        test_errs = 0;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        rst          = 1'b1;
        i_req        = 1'b0;
        i_addr       = '0;
        d_req        = 1'b0;
        d_we         = 1'b0;
        d_addr       = '0;
        d_wdata      = '0;
        i_vld_ref    = '0;
        d_vld_ref    = '0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        for (int w = 0; w < `MEM_WORDS; w++)
            ref_mem[w] = '0;                  // Memory starts at zero

        // Test 1 checks quiet outputs through reset and just after
        cur_test = 1;
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            if (c == 7)
                rst <= 1'b0;                  // Eighth edge is the last in reset
            @(negedge clk);
            if (i_valid !== 1'b0) begin
                $display("mismatch i_valid after reset cycle %0d: expected 0, got %h", c, i_valid);
                test_errs++;
            end
            if (d_valid !== 1'b0) begin
                $display("mismatch d_valid after reset cycle %0d: expected 0, got %h", c, d_valid);
                test_errs++;
            end
        end

        fd = $fopen("tb/cache_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file tb/cache_stim.txt");
            test_errs++;
            aborted = 1'b1;
        end
        while (!aborted) begin
            read_line(0, ok);
            if (!ok)
                break;
            if (tnum[0] != cur_test) begin
                finish_test(cur_test);
                cur_test = tnum[0];
            end
            n_acc  = 1;
            off[0] = 0;
            if (op[0][15:8] == "P" || op[0][15:8] == "L") begin
                read_line(1, ok);
                if (!ok) begin
                    $display("stimulus file ends inside a pair of test %0d", cur_test);
                    test_errs++;
                    break;
                end
                n_acc  = 2;
                off[1] = (op[0][15:8] == "L") ? 2 : 0;  // L staggers the partner
            end
            predict();
            run_access();
            if (!aborted)
                check_group();
        end
        if (fd != 0)
            $fclose(fd);

        finish_test(cur_test);
        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== cache_sys.f ====
+incdir+include
hdl/cache_pkg.sv
hdl/cache_arbiter.sv
hdl/icache.sv
hdl/dcache.sv
hdl/main_memory.sv
hdl/cache_top.sv
tb/tb_cache_top.sv

// ==== Makefile ====
# Verilator build, run and lint for the cache system

TOP   = tb_cache_top
FLIST = cache_sys.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FLIST) $(wildcard hdl/*.sv include/*.svh tb/*.sv)
	verilator --binary --timing -f $(FLIST) --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f $(FLIST) --top-module cache_top

clean:
	rm -rf obj_dir sim.log

// ==== tb/cache_stim.txt ====
# test side op addr wdata expected (hex fields)
# op R or W; a P prefix pairs it with the next line in the same cycle, L two cycles later

# D write then D read hit
2  D  W   010  deadbeef  deadbeef
2  D  R   010  00000000  deadbeef
2  D  W   023  12345678  12345678
2  D  R   023  00000000  12345678

# I fetch of D-written words, miss then hit
3  I  R   010  00000000  deadbeef
3  I  R   010  00000000  deadbeef
3  I  R   023  00000000  12345678
3  I  R   023  00000000  12345678

# Conflict eviction on D line 5
4  D  W   105  a5a5a5a5  a5a5a5a5
4  D  W   205  5a5a5a5a  5a5a5a5a
4  D  R   105  00000000  a5a5a5a5
4  D  R   205  00000000  5a5a5a5a

# Simultaneous I and D read misses
5  D  W   032  cafef00d  cafef00d
5  D  W   041  0badf00d  0badf00d
5  D  W   141  11112222  11112222
5  I  PR  032  00000000  cafef00d
5  D  R   041  00000000  0badf00d
5  I  PR  060  00000000  00000000
5  D  R   070  00000000  00000000

# D write preempted by an I miss, then read back from the line and from memory
6  D  LW  0a7  87654321  87654321
6  I  R   141  00000000  11112222
6  D  R   0a7  00000000  87654321
6  D  W   1a7  13572468  13572468
6  D  R   0a7  00000000  87654321
